// File: hdl/alu_pkg.sv
// Shared ALU definitions: data width, RV32I opcodes, funct codes, ALU operations, CSR fields
package alu_pkg;

    localparam int xlen = 32;                       // Integer data width

    // ----------------------------------------------------------
    // Major opcodes accepted by the execute unit
    // ----------------------------------------------------------
    typedef enum logic [6:0] {
        op_imm = 7'b00_100_11,                      // I-type arithmetic and logic
        auipc  = 7'b00_101_11,                      // Add upper immediate to pc
        op     = 7'b01_100_11                       // R-type arithmetic and logic
    } opcode_t;

    // funct7 patterns, alt selects SUB and SRA
    localparam logic [6:0] funct7_base = 7'b000_0000;
    localparam logic [6:0] funct7_alt  = 7'b010_0000;

    // funct3 codes, shared by OP and OP_IMM
    localparam logic [2:0] f3_add  = 3'b000;        // ADD, SUB, ADDI
    localparam logic [2:0] f3_sll  = 3'b001;        // Shift left logical
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;        // SRL or SRA by funct7
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // ----------------------------------------------------------
    // Internal ALU operations, decode to execute
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // Accuracy control word, bits 2:1 (circuit select) are not used here
    localparam int acc_approx_bit = 0;              // 1 = approximate, 0 = exact
    localparam int acc_error_lsb  = 3;              // First per-bit error enable

endpackage

// File: hdl/approx_adder.sv
// Error-configurable carry-select adder, approximable low region and exact upper region
`timescale 1ns/1ns

module approx_adder #(
    parameter int xlen    = alu_pkg::xlen,
    parameter int apx_len = 8                       // Multiple of 4, from 4 to xlen
) (
    input  logic [apx_len-1:0] error_enable,        // High = exact bit
    input  logic [xlen-1:0]    a,
    input  logic [xlen-1:0]    b,
    input  logic               carry_in,
    output logic [xlen-1:0]    sum,
    output logic               carry_out
);

    logic [xlen-1:0]   er_full;                     // Error enables, ones above apx_len
    logic [xlen-1:0]   raw_sum;                     // Group sums assuming no group carry in
    logic [xlen:0]     ripple_c;                    // Local ripple carries inside each group
    logic [xlen/4:1]   grp_c;                       // Selected carry out of each group

    assign ripple_c[0] = carry_in;

    genvar k;
    genvar g;

    // ----------------------------------------------------------
    // Bit cells
    // ----------------------------------------------------------
    generate
        for (k = 0; k < xlen; k++) begin : g_bit
            logic p;                                // Propagate term
            assign p = a[k] ^ b[k];

            if (k < apx_len) begin : g_cfg
                assign er_full[k] = error_enable[k];
            end else begin : g_exact
                assign er_full[k] = 1'b1;           // Upper region always exact
            end

            if ((k % 4 == 0) && (k > 0)) begin : g_half
                // Low bit of a select group has no local carry in
                assign raw_sum[k]    = p;
                assign ripple_c[k+1] = a[k] & b[k];
            end else begin : g_cell
                // Exact full adder when enabled, else sum = p | cin
                assign raw_sum[k]    = ~(er_full[k] & p & ripple_c[k]) & (p | ripple_c[k]);
                assign ripple_c[k+1] = (er_full[k] & b[k] & ripple_c[k])
                                     | ((b[k] | ripple_c[k]) & a[k]);
            end
        end
    endgenerate

    // ----------------------------------------------------------
    // Group 0 ripples straight from carry_in
    // ----------------------------------------------------------
    assign sum[3:0] = raw_sum[3:0];
    assign grp_c[1] = ripple_c[4];

    // Upper groups: incrementer plus select on the incoming group carry
    generate
        for (g = 1; g < xlen / 4; g++) begin : g_group
            logic [3:0] grp_raw;
            logic [3:0] grp_inc;
            logic       inc_c;                      // Incrementer wraps

            assign grp_raw = raw_sum[4*g +: 4];
            assign grp_inc = grp_raw + 4'd1;
            assign inc_c   = &grp_raw;

            assign sum[4*g +: 4] = grp_c[g] ? grp_inc : grp_raw;
            assign grp_c[g+1]    = ripple_c[4*g+4] | (grp_c[g] & inc_c);
        end
    endgenerate

    assign carry_out = grp_c[xlen/4];               // Carry out of the top group

endmodule

// File: hdl/alu_decode.sv
// Decode stage: field to ALU operation mapping, operand select, pipeline register
`timescale 1ns/1ns

module alu_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic [6:0]               opcode,
    input  logic [2:0]               funct3,
    input  logic [6:0]               funct7,
    input  logic [alu_pkg::xlen-1:0] rs1,
    input  logic [alu_pkg::xlen-1:0] rs2,
    input  logic [alu_pkg::xlen-1:0] immediate,
    input  logic [alu_pkg::xlen-1:0] pc,
    input  logic [31:0]              accuracy_control,
    output logic                     dec_valid,
    output logic                     dec_illegal,
    output alu_pkg::alu_op_t         dec_op,
    output logic [alu_pkg::xlen-1:0] dec_operand_a,
    output logic [alu_pkg::xlen-1:0] dec_operand_b,
    output logic [31:0]              dec_accuracy
);

    import alu_pkg::*;

    alu_op_t         next_op;
    logic            next_illegal;
    logic [xlen-1:0] next_a;
    logic [xlen-1:0] next_b;
    logic            is_alt;                        // funct7 asks for SUB or SRA

    assign is_alt = (funct7 == funct7_alt);

    // ----------------------------------------------------------
    // Operation and operand select
    // ----------------------------------------------------------
    always_comb begin
        next_op      = alu_add;
        next_illegal = 1'b0;
        next_a       = rs1;
        next_b       = rs2;
        case (opcode_t'(opcode))
            op: begin                               // R-type, rs1 and rs2
                if ((funct7 != funct7_base) && !is_alt)
                    next_illegal = 1'b1;
                if (is_alt && (funct3 != f3_add) && (funct3 != f3_sr))
                    next_illegal = 1'b1;            // Only SUB and SRA use alt
                case (funct3)
                    f3_add:  next_op = is_alt ? alu_sub : alu_add;
                    f3_sll:  next_op = alu_sll;
                    f3_slt:  next_op = alu_slt;
                    f3_sltu: next_op = alu_sltu;
                    f3_xor:  next_op = alu_xor;
                    f3_sr:   next_op = is_alt ? alu_sra : alu_srl;
                    f3_or:   next_op = alu_or;
                    default: next_op = alu_and;
                endcase
            end
            op_imm: begin                           // I-type, rs1 and immediate
                next_b = immediate;
                case (funct3)
                    f3_add:  next_op = alu_add;     // No SUBI in RV32I
                    f3_sll: begin
                        next_op      = alu_sll;
                        next_illegal = (immediate[11:5] != funct7_base);
                    end
                    f3_slt:  next_op = alu_slt;
                    f3_sltu: next_op = alu_sltu;
                    f3_xor:  next_op = alu_xor;
                    f3_sr: begin                    // Upper immediate picks SRLI or SRAI
                        next_op      = (immediate[11:5] == funct7_alt) ? alu_sra : alu_srl;
                        next_illegal = (immediate[11:5] != funct7_base)
                                     && (immediate[11:5] != funct7_alt);
                    end
                    f3_or:   next_op = alu_or;
                    default: next_op = alu_and;
                endcase
            end
            auipc: begin
                next_a = pc;                        // pc + immediate
                next_b = immediate;
            end
            default: next_illegal = 1'b1;           // Unsupported opcode
        endcase
    end

    // ----------------------------------------------------------
    // Stage register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid   <= 1'b0;
            dec_illegal <= 1'b0;
            dec_op      <= alu_add;
        end else begin
            dec_valid   <= in_valid;
            dec_illegal <= next_illegal;
            dec_op      <= next_op;
        end
        dec_operand_a <= next_a;                    // Payload, no reset
        dec_operand_b <= next_b;
        dec_accuracy  <= accuracy_control;
    end

endmodule

// File: hdl/alu_execute.sv
// Execute stage: approximate adder, shifter, comparators, logic ops and result register
`timescale 1ns/1ns

module alu_execute #(
    parameter int apx_len = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dec_valid,
    input  logic                     dec_illegal,
    input  alu_pkg::alu_op_t         dec_op,
    input  logic [alu_pkg::xlen-1:0] dec_operand_a,
    input  logic [alu_pkg::xlen-1:0] dec_operand_b,
    input  logic [31:0]              dec_accuracy,
    output logic                     exe_valid,
    output logic                     exe_illegal,
    output logic [alu_pkg::xlen-1:0] exe_result,
    output logic                     exe_approximate
);

    import alu_pkg::*;

    logic               is_sub;
    logic               is_addsub;
    logic [xlen-1:0]    adder_b;
    logic [xlen-1:0]    adder_sum;
    logic [apx_len-1:0] err_field;                  // Raw error enables from the CSR
    logic [apx_len-1:0] error_enable;
    logic               approx_mode;
    logic [4:0]         shamt;
    logic               lt_signed;
    logic               lt_unsigned;
    logic [xlen-1:0]    raw_result;

    // ----------------------------------------------------------
    // Adder control
    // ----------------------------------------------------------
    assign is_sub      = (dec_op == alu_sub);
    assign is_addsub   = (dec_op == alu_add) || is_sub;
    assign adder_b     = is_sub ? ~dec_operand_b : dec_operand_b;   // a + ~b + 1
    assign approx_mode = dec_accuracy[acc_approx_bit];
    assign err_field   = dec_accuracy[acc_error_lsb +: apx_len];
    // Exact mode forces every bit exact
    assign error_enable = err_field | {apx_len{~approx_mode}};

    approx_adder #(
        .xlen    (xlen),
        .apx_len (apx_len)
    ) adder_i (
        .error_enable (error_enable),
        .a            (dec_operand_a),
        .b            (adder_b),
        .carry_in     (is_sub),
        .sum          (adder_sum),
        .carry_out    ()                            // Not needed for RV32I
    );

    // Shift amount, low 5 bits only
    assign shamt       = dec_operand_b[4:0];
    assign lt_signed   = $signed(dec_operand_a) < $signed(dec_operand_b);
    assign lt_unsigned = dec_operand_a < dec_operand_b;

    // ----------------------------------------------------------
    // Result select
    // ----------------------------------------------------------
    always_comb begin
        case (dec_op)
            alu_add,
            alu_sub:  raw_result = adder_sum;
            alu_sll:  raw_result = dec_operand_a << shamt;
            alu_slt:  raw_result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: raw_result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:  raw_result = dec_operand_a ^ dec_operand_b;
            alu_srl:  raw_result = dec_operand_a >> shamt;
            alu_sra:  raw_result = $unsigned($signed(dec_operand_a) >>> shamt);  // Sign fill
            alu_or:   raw_result = dec_operand_a | dec_operand_b;
            alu_and:  raw_result = dec_operand_a & dec_operand_b;
            default:  raw_result = '0;
        endcase
    end

    // Stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_valid       <= 1'b0;
            exe_illegal     <= 1'b0;
            exe_approximate <= 1'b0;
        end else begin
            exe_valid       <= dec_valid;
            exe_illegal     <= dec_illegal;
            // Flag only when the adder ran with some bit approximated
            exe_approximate <= is_addsub && approx_mode && !(&err_field);
        end
        exe_result <= raw_result;                   // Payload, no reset
    end

endmodule

// File: hdl/alu_result.sv
// Result stage: illegal masking, writeback registers, approximation flag
`timescale 1ns/1ns

module alu_result (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     exe_valid,
    input  logic                     exe_illegal,
    input  logic [alu_pkg::xlen-1:0] exe_result,
    input  logic                     exe_approximate,
    output logic                     out_valid,
    output logic [alu_pkg::xlen-1:0] result,
    output logic                     illegal,
    output logic                     approximate
);

    // ----------------------------------------------------------
    // Writeback register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            result      <= '0;
            illegal     <= 1'b0;
            approximate <= 1'b0;
        end else begin
            out_valid <= exe_valid;                 // Strobe, one cycle per result
            if (exe_valid) begin
                // Illegal work writes zero and never claims approximation
                result      <= exe_illegal ? '0 : exe_result;
                illegal     <= exe_illegal;
                approximate <= exe_approximate && !exe_illegal;
            end
            // Held otherwise, so late sampling still sees the last result
        end
    end

endmodule

// File: hdl/alu_top.sv
// Top level of the approximate integer execute unit, three pipeline stages
`timescale 1ns/1ns

module alu_top #(
    parameter int apx_len = 8                       // Approximable low adder bits
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic [6:0]               opcode,
    input  logic [2:0]               funct3,
    input  logic [6:0]               funct7,
    input  logic [alu_pkg::xlen-1:0] rs1,
    input  logic [alu_pkg::xlen-1:0] rs2,
    input  logic [alu_pkg::xlen-1:0] immediate,
    input  logic [alu_pkg::xlen-1:0] pc,
    input  logic [31:0]              accuracy_control,
    output logic                     out_valid,
    output logic [alu_pkg::xlen-1:0] result,
    output logic                     illegal,
    output logic                     approximate
);

    import alu_pkg::*;

    // ----------------------------------------------------------
    // Decode to execute
    // ----------------------------------------------------------
    logic            dec_valid;
    logic            dec_illegal;
    alu_op_t         dec_op;
    logic [xlen-1:0] dec_operand_a;
    logic [xlen-1:0] dec_operand_b;
    logic [31:0]     dec_accuracy;

    // Execute to result
    logic            exe_valid;
    logic            exe_illegal;
    logic [xlen-1:0] exe_result;
    logic            exe_approximate;

    alu_decode decode_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .opcode           (opcode),
        .funct3           (funct3),
        .funct7           (funct7),
        .rs1              (rs1),
        .rs2              (rs2),
        .immediate        (immediate),
        .pc               (pc),
        .accuracy_control (accuracy_control),
        .dec_valid        (dec_valid),
        .dec_illegal      (dec_illegal),
        .dec_op           (dec_op),
        .dec_operand_a    (dec_operand_a),
        .dec_operand_b    (dec_operand_b),
        .dec_accuracy     (dec_accuracy)
    );

    alu_execute #(
        .apx_len (apx_len)
    ) execute_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .dec_valid       (dec_valid),
        .dec_illegal     (dec_illegal),
        .dec_op          (dec_op),
        .dec_operand_a   (dec_operand_a),
        .dec_operand_b   (dec_operand_b),
        .dec_accuracy    (dec_accuracy),
        .exe_valid       (exe_valid),
        .exe_illegal     (exe_illegal),
        .exe_result      (exe_result),
        .exe_approximate (exe_approximate)
    );

    alu_result result_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .exe_valid       (exe_valid),
        .exe_illegal     (exe_illegal),
        .exe_result      (exe_result),
        .exe_approximate (exe_approximate),
        .out_valid       (out_valid),
        .result          (result),
        .illegal         (illegal),
        .approximate     (approximate)
    );

endmodule

// File: sim/alu_tb.sv
// Testbench for the approximate execute unit: stimulus, reference model, assertions, summary
`timescale 1ns/1ns

module alu_tb;

    import alu_pkg::*;

    localparam int apx_len        = 8;
    localparam int num_instr      = 200 + 20 + 61 + 20 + 3 + 12;   // All tests together
    localparam int timeout_cycles = num_instr + 50;

    logic            clk;
    logic            rst_n;
    logic            in_valid = 1'b0;                   // Known history for the strobe check
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] immediate;
    logic [xlen-1:0] pc;
    logic [31:0]     accuracy_control;
    logic            out_valid;
    logic [xlen-1:0] result;
    logic            illegal;
    logic            approximate;

    // Expected results in issue order
    logic [xlen-1:0] exp_result  [0:511];
    logic            exp_illegal [0:511];
    logic            exp_approx  [0:511];
    string           exp_name    [0:511];
    int              wr_idx = 0;
    int              rd_idx = 0;
    int              errors = 0;
    int              checks = 0;
    int              cycles = 0;
    integer          seed;

    alu_top #(.apx_len(apx_len)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                          // 4 ns period
    end

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic logic [xlen-1:0] model_add(input logic [xlen-1:0] a,
            input logic [xlen-1:0] b, input logic cin, input logic [xlen-1:0] exact);
        logic [xlen-1:0] s;
        logic [3:0]      grp;
        logic            c;
        logic            gc;                            // Carry between groups
        int              i;
        gc = 1'b0;
        for (int g = 0; g < xlen / 4; g++) begin
            c = (g == 0) ? cin : 1'b0;
            for (int k = 0; k < 4; k++) begin
                i = 4 * g + k;
                if (g > 0 && k == 0) begin              // Half adder on group low bit
                    grp[k] = a[i] ^ b[i];
                    c      = a[i] & b[i];
                end else if (exact[i]) begin
                    grp[k] = a[i] ^ b[i] ^ c;
                    c      = (a[i] & b[i]) | (c & (a[i] ^ b[i]));
                end else begin                          // Approximate cell
                    grp[k] = (a[i] ^ b[i]) | c;
                    c      = (b[i] | c) & a[i];
                end
            end
            s[4*g +: 4] = gc ? grp + 4'd1 : grp;        // Carry select
            gc = c | (gc & (&grp));
        end
        return s;
    endfunction

    // Expected values for the inputs now driven
    task automatic predict(input string name);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        logic [xlen-1:0] exact;
        logic            bad;
        logic            alt;
        logic            is_sub;
        a     = (opcode == auipc) ? pc : rs1;
        b     = (opcode == op) ? rs2 : immediate;
        alt   = (opcode == op) ? (funct7 == funct7_alt) : (immediate[11:5] == funct7_alt);
        bad   = 1'b0;
        if (opcode == op)
            bad = (funct7 != funct7_base && !alt) || (alt && funct3 != f3_add && funct3 != f3_sr);
        else if (opcode == op_imm)
            bad = (funct3 == f3_sll && immediate[11:5] != funct7_base)
                || (funct3 == f3_sr && immediate[11:5] != funct7_base && !alt);
        else if (opcode != auipc)
            bad = 1'b1;                                 // Unknown opcode
        is_sub = (opcode == op) && (funct3 == f3_add) && alt;
        exact  = '1;
        if (accuracy_control[acc_approx_bit])
            exact[apx_len-1:0] = accuracy_control[acc_error_lsb +: apx_len];
        case ((opcode == auipc) ? f3_add : funct3)
            f3_add:  res = model_add(a, is_sub ? ~b : b, is_sub, exact);
            f3_sll:  res = a << b[4:0];
            f3_slt:  res = ($signed(a) < $signed(b)) ? 1 : 0;
            f3_sltu: res = (a < b) ? 1 : 0;
            f3_xor:  res = a ^ b;
            f3_sr:   res = (a >> b[4:0]) | ((alt && a[31]) ? ~('1 >> b[4:0]) : '0);
            f3_or:   res = a | b;
            default: res = a & b;
        endcase
        exp_result[wr_idx]  = bad ? '0 : res;
        exp_illegal[wr_idx] = bad;
        exp_approx[wr_idx]  = !bad && (opcode == auipc || funct3 == f3_add)
                            && accuracy_control[acc_approx_bit]
                            && !(&accuracy_control[acc_error_lsb +: apx_len]);
        exp_name[wr_idx]    = name;
    endtask

    // ----------------------------------------------------------
    // Stimulus helpers, driven on the falling edge
    // ----------------------------------------------------------
    task automatic issue(input string name, input logic [6:0] opc, input logic [2:0] f3,
            input logic [6:0] f7, input logic [xlen-1:0] a, input logic [xlen-1:0] b,
            input logic [31:0] acc);
        @(negedge clk);
        in_valid         = 1'b1;
        opcode           = opc;
        funct3           = f3;
        funct7           = f7;
        rs1              = (opc == auipc) ? ~a : a;     // Unselected operands carry other values
        pc               = (opc == auipc) ? a : ~a;
        rs2              = (opc == op) ? b : ~b;
        immediate        = (opc == op) ? ~b : b;
        accuracy_control = acc;
        predict(name);
        wr_idx++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    function automatic logic [xlen-1:0] pick_operand();
        case ($unsigned($random(seed)) % 8)             // Edge values now and then
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'h7fff_ffff;
            3:       return 32'hffff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    task automatic random_alu(input string name, input logic [31:0] acc);
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [6:0]      opc;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        f3  = $random(seed);
        opc = ($random(seed) & 1) ? op : op_imm;
        a   = pick_operand();
        b   = pick_operand();
        f7  = funct7_base;
        if (opc == op && (f3 == f3_add || f3 == f3_sr) && ($random(seed) & 1))
            f7 = funct7_alt;                            // SUB or SRA
        if (opc == op_imm) begin
            b = {{20{b[11]}}, b[11:0]};                 // 12-bit immediate
            if (f3 == f3_sll)
                b[11:5] = funct7_base;
            if (f3 == f3_sr)
                b[11:5] = ($random(seed) & 1) ? funct7_alt : funct7_base;
        end
        issue(name, opc, f3, f7, a, b, acc);
    endtask

    // ----------------------------------------------------------
    // Checking
    // ----------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            rd_idx <= rd_idx + 1;
            checks <= checks + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |->
        {result, illegal, approximate}
            == {exp_result[rd_idx], exp_illegal[rd_idx], exp_approx[rd_idx]})
    else begin
        errors++;
        $display("Error %s: expected %h/%b/%b, actual %h/%b/%b",
            exp_name[$sampled(rd_idx)], exp_result[$sampled(rd_idx)],
            exp_illegal[$sampled(rd_idx)], exp_approx[$sampled(rd_idx)],
            $sampled(result), $sampled(illegal), $sampled(approximate));
    end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 3))
    else begin
        errors++;
        $display("valid strobe out of step at %0t", $time);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("Run stopped after %0d cycles, results still missing", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        logic [xlen-1:0] a;
        logic [31:0]     all_ones;
        seed             = 10;
        all_ones         = 32'h1 | (((32'h1 << apx_len) - 1) << acc_error_lsb);
        rst_n            = 1'b0;
        in_valid         = 1'b0;
        opcode           = '0;
        funct3           = '0;
        funct7           = '0;
        rs1              = '0;
        rs2              = '0;
        immediate        = '0;
        pc               = '0;
        accuracy_control = '0;
        repeat (2) @(posedge clk);                      // Reset for 2 cycles
        @(negedge clk);
        rst_n = 1'b1;
        idle(3);                                        // No output before first issue
        for (int i = 0; i < 200; i++)
            random_alu("exact", 32'h0);
        for (int i = 0; i < 20; i++)
            issue("auipc", auipc, 3'd0, 7'd0, $random(seed) & ~32'h3, $random(seed) << 12, 0);
        issue("approx_sub_zero", op, f3_add, funct7_alt, 0, 0, 32'h1);
        for (int i = 0; i < 20; i++) begin
            a = $random(seed);
            issue("approx_disjoint", op, f3_add, funct7_base, a, $random(seed) & ~a, 32'h1);
        end
        for (int i = 0; i < 40; i++)
            issue("approx_random", op, f3_add, funct7_base, $random(seed), $random(seed), 32'h1);
        for (int i = 0; i < 20; i++)
            issue("error_all_ones", op, f3_add, ($random(seed) & 1) ? funct7_alt : funct7_base,
                $random(seed), $random(seed), all_ones);
        issue("illegal_opcode", 7'b000_0011, f3_add, funct7_base, 5, 7, 32'h1);
        issue("illegal_funct7", op, f3_add, 7'b000_0001, 5, 7, 32'h1);
        issue("illegal_slli", op_imm, f3_sll, funct7_base, 5, 32'h0000_0405, 32'h1);
        for (int i = 0; i < 12; i++) begin              // Gaps mixed with back to back
            random_alu("pipeline", 32'h0);
            if (i % 3 != 2)
                idle(1 + $unsigned($random(seed)) % 2);
        end
        idle(1);
        while (rd_idx != wr_idx)
            @(posedge clk);
        @(negedge clk);
        if (wr_idx != num_instr) begin
            errors++;
            $display("Issued %0d instructions, the timeout assumes %0d", wr_idx, num_instr);
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: src.f
hdl/alu_pkg.sv
hdl/approx_adder.sv
hdl/alu_decode.sv
hdl/alu_execute.sv
hdl/alu_result.sv
hdl/alu_top.sv
sim/alu_tb.sv
